/* filelist.f */
+incdir+rtl
rtl/cpc_loader_pkg.sv
rtl/cpc_bus_pkg.sv
rtl/cpc_clock_enables.sv
rtl/cpc_mem_router.sv
rtl/cpc_tape_fetch.sv
rtl/cpc_multiface2.sv
rtl/cpc_support_top.sv
dv/tb_cpc_support.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_cpc_support -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"
[ -f sim.log ] && cat sim.log || { cat build.log; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

/* dv/tb_cpc_support.sv */
// testbench for cpc_support_top; sdram tape port and cpu bus are stand-ins driven here
// checks sample at the falling edge, stimulus changes on the rising edge
`timescale 1ns/1ps

module tb_cpc_support;

	localparam int RESET_CYCLES = 10;
	localparam int TAPE_BYTES   = 4;
	// a few hundred cycles of stimulus, ack gaps of up to 5 cycles, wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	// download kind codes in order: none, rom, disk, expansion, tape
	localparam logic [2:0] DL_NONE = 3'd0;
	localparam logic [2:0] DL_ROM  = 3'd1;
	localparam logic [2:0] DL_EXT  = 3'd3;
	localparam logic [2:0] DL_TAPE = 3'd4;

	logic        clk_sys = 1'b0;
	logic        hard_reset;
	logic        reset_req_i;
	logic        model_i;
	logic        ioctl_download_i;
	logic        ioctl_wr_i;
	logic [7:0]  ioctl_index_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0]  ioctl_dout_i;
	logic [15:0] ioctl_file_ext_i;
	logic        rom_hidden_i;
	logic        mem_rd_i;
	logic        mem_wr_i;
	logic [22:0] mem_addr_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_dout_i;
	logic        tape_ack_i;
	logic        tape_data_req_i;
	logic [1:0]  mf2_mode_i;
	logic        key_nmi_i;
	logic        m1_i;
	logic        io_wr_i;

	logic        ce_4p_o, ce_4n_o, ce_8_o, ce_16_o;
	logic [2:0]  dl_kind_o;
	logic        sdram_oe_o, sdram_we_o;
	logic [22:0] sdram_addr_o;
	logic [1:0]  sdram_bank_o;
	logic [7:0]  sdram_din_o;
	logic        rom_mask_o;
	logic [22:0] tape_addr_o;
	logic        tape_wr_o, tape_rd_o, tape_data_ack_o, tape_restart_o;
	logic        nmi_o, mf2_rom_en_o, mf2_ram_en_o;
	logic [7:0]  mf2_dout_o;
	logic        cpu_reset_o, model_o;

	int err_count = 0;
	int cyc = 0;
	int last_16 = -1;
	int last_8 = -1;
	int last_4p = -1;
	int wr_pulses = 0;
	int rd_pulses = 0;
	logic prev_tape_wr = 1'b0;
	logic prev_tape_rd = 1'b0;
	logic rom_dl_active = 1'b0;

	cpc_support_top dut0 (.*);

	always #2 clk_sys = ~clk_sys;

	task automatic fail_stop();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got === exp) else begin
			err_count++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			fail_stop();
		end
	endtask

	// rom image block to sdram page: lower, basic, amsdos, mf2
	function automatic logic [8:0] rom_block_page(input int blk);
		case (blk % 4)
			0:       return 9'h000;
			1:       return 9'h100;
			2:       return 9'h107;
			default: return 9'h1FF;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// monitors

	always @(negedge clk_sys) begin
		if (hard_reset) begin
			check_value("ce_enables_in_reset", {ce_4p_o, ce_4n_o, ce_8_o, ce_16_o}, 4'h0);
		end else begin
			cyc++;
			if (ce_16_o) begin
				if (last_16 >= 0)
					check_value("ce_16_o period", cyc - last_16, 4);
				last_16 = cyc;
			end
			if (ce_8_o) begin
				if (last_8 >= 0)
					check_value("ce_8_o period", cyc - last_8, 8);
				last_8 = cyc;
			end
			if (ce_4p_o) begin
				if (last_4p >= 0)
					check_value("ce_4p_o period", cyc - last_4p, 16);
				last_4p = cyc;
			end
			if (ce_4n_o && last_4p >= 0)
				check_value("ce_4n_o after ce_4p_o", cyc - last_4p, 8);
		end
		if (rom_dl_active)
			check_value("cpu_reset_o", cpu_reset_o, 1'b1);
		if (tape_wr_o && !prev_tape_wr)
			wr_pulses++;
		if (tape_rd_o && !prev_tape_rd)
			rd_pulses++;
		prev_tape_wr = tape_wr_o;
		prev_tape_rd = tape_rd_o;
	end

	// sdram stand-in, toggles the ack 1-5 cycles after a tape request
	initial begin : sdram_model
		int unsigned gap;
		forever begin
			@(negedge clk_sys);
			if (tape_wr_o || tape_rd_o) begin
				gap = $urandom_range(5, 1);
				repeat (gap) @(posedge clk_sys);
				tape_ack_i <= ~tape_ack_i;
				do @(negedge clk_sys); while (tape_wr_o || tape_rd_o);
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
		$display("watchdog expired: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		fail_stop();
	end

	//////////////////////////////////////////////////
	// stimulus

	initial begin : main
		int          off;
		logic [7:0]  data;
		logic [8:0]  page;

		void'($urandom(86));
		hard_reset       = 1'b1;
		reset_req_i      = 1'b0;
		model_i          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_index_i    = 8'd0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = 8'h00;
		ioctl_file_ext_i = 16'h0000;
		rom_hidden_i     = 1'b0;
		mem_rd_i         = 1'b0;
		mem_wr_i         = 1'b0;
		mem_addr_i       = '0;
		cpu_addr_i       = 16'h8000;
		cpu_dout_i       = 8'h00;
		tape_ack_i       = 1'b0;
		tape_data_req_i  = 1'b0;
		mf2_mode_i       = 2'd0;
		key_nmi_i        = 1'b0;
		m1_i             = 1'b0;
		io_wr_i          = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		hard_reset <= 1'b0;
		repeat (40) @(posedge clk_sys); // let the enable checks run a while

		// rom download, blocks 0-7 mapped, block 8 dropped
		ioctl_index_i    <= 8'd0;
		ioctl_download_i <= 1'b1;
		model_i          <= 1'b1; // taken over while the cpu sits in reset
		repeat (2) @(posedge clk_sys);
		rom_dl_active = 1'b1;
		for (int b = 0; b < 9; b++) begin
			off  = $urandom_range(16383, 0);
			data = $urandom;
			ioctl_addr_i <= b * 16384 + off;
			ioctl_dout_i <= data;
			ioctl_wr_i   <= 1'b1;
			@(negedge clk_sys);
			check_value("dl_kind_o", dl_kind_o, DL_ROM);
			check_value("sdram_we_o", sdram_we_o, b < 8);
			if (b < 8) begin
				check_value("sdram_addr_o", sdram_addr_o, {rom_block_page(b), off[13:0]});
				check_value("sdram_bank_o", sdram_bank_o, b >= 4);
				check_value("sdram_din_o", sdram_din_o, data);
			end
			@(posedge clk_sys);
			ioctl_wr_i <= 1'b0;
			@(posedge clk_sys);
		end
		rom_dl_active = 1'b0;
		ioctl_download_i <= 1'b0;
		do @(negedge clk_sys); while (cpu_reset_o);
		check_value("model_o", model_o, 1'b1);

		// expansion rom with extension "3A", upper half page 3A plus block
		@(posedge clk_sys);
		ioctl_index_i    <= 8'd3;
		ioctl_file_ext_i <= 16'h3341;
		ioctl_download_i <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int b = 0; b < 2; b++) begin
			off  = $urandom_range(16383, 0);
			data = $urandom;
			page = {1'b1, 8'h3A + 8'(b)};
			ioctl_addr_i <= b * 16384 + off;
			ioctl_dout_i <= data;
			ioctl_wr_i   <= 1'b1;
			@(negedge clk_sys);
			check_value("dl_kind_o", dl_kind_o, DL_EXT);
			check_value("sdram_we_o", sdram_we_o, 1'b1);
			check_value("sdram_addr_o", sdram_addr_o, {page, off[13:0]});
			@(posedge clk_sys);
			ioctl_wr_i <= 1'b0;
			@(posedge clk_sys);
		end
		ioctl_download_i <= 1'b0;
		do @(negedge clk_sys); while (cpu_reset_o);

		// cpu reads, loaded upper page 3A then an unloaded one
		@(posedge clk_sys);
		mem_rd_i   <= 1'b1;
		mem_addr_i <= {1'b1, 8'h3A, 14'h0123};
		model_i    <= 1'b0; // cpu running, model must hold
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("rom_mask_o", rom_mask_o, 1'b0);
		check_value("sdram_oe_o", sdram_oe_o, 1'b1);
		check_value("dl_kind_o", dl_kind_o, DL_NONE);
		@(posedge clk_sys);
		mem_addr_i <= {1'b1, 8'h55, 14'h0123};
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("rom_mask_o", rom_mask_o, 1'b1);
		check_value("sdram_oe_o", sdram_oe_o, 1'b0);
		check_value("model_o", model_o, 1'b1);
		@(posedge clk_sys);
		mem_rd_i <= 1'b0;

		// tape download, one acked store per write
		ioctl_index_i    <= 8'd4;
		ioctl_download_i <= 1'b1;
		for (int i = 0; i < TAPE_BYTES; i++) begin
			@(posedge clk_sys);
			ioctl_addr_i <= i;
			ioctl_wr_i   <= 1'b1;
			@(negedge clk_sys);
			check_value("tape_addr_o", tape_addr_o, i);
			check_value("dl_kind_o", dl_kind_o, DL_TAPE);
			check_value("tape_restart_o", tape_restart_o, 1'b1);
			@(posedge clk_sys);
			ioctl_wr_i <= 1'b0;
			do @(negedge clk_sys); while (!tape_wr_o);
			do @(negedge clk_sys); while (tape_wr_o);
		end
		check_value("tape_wr_o pulses", wr_pulses, TAPE_BYTES);
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (3) @(posedge clk_sys);

		// playback, one fetch per player request toggle
		for (int k = 0; k < TAPE_BYTES; k++) begin
			tape_data_req_i <= ~tape_data_req_i;
			do @(negedge clk_sys); while (!tape_rd_o);
			check_value("tape_addr_o", tape_addr_o, k);
			check_value("tape_restart_o", tape_restart_o, 1'b0);
			do @(negedge clk_sys); while (tape_data_ack_o != tape_data_req_i);
			check_value("tape_addr_o", tape_addr_o, k + 1);
			check_value("tape_rd_o pulses", rd_pulses, k + 1);
			@(posedge clk_sys);
		end
		tape_data_req_i <= ~tape_data_req_i; // past the end, must be ignored
		repeat (20) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("tape_rd_o pulses", rd_pulses, TAPE_BYTES);
		check_value("tape_data_ack_o", tape_data_ack_o, !tape_data_req_i);

		// multiface: nmi, page in at 0066, shadowed pen write, page out
		@(posedge clk_sys);
		key_nmi_i <= 1'b1;
		@(posedge clk_sys);
		key_nmi_i <= 1'b0;
		@(negedge clk_sys);
		check_value("nmi_o", nmi_o, 1'b1);
		@(posedge clk_sys);
		cpu_addr_i <= 16'h0066;
		m1_i       <= 1'b1;
		@(posedge clk_sys);
		m1_i <= 1'b0;
		@(negedge clk_sys);
		check_value("nmi_o", nmi_o, 1'b0);
		check_value("mf2_rom_en_o", mf2_rom_en_o, 1'b1);
		@(posedge clk_sys);
		cpu_addr_i <= 16'h0123;
		mem_addr_i <= 23'h000123;
		mem_rd_i   <= 1'b1;
		@(negedge clk_sys);
		check_value("sdram_addr_o", sdram_addr_o, {9'h1FF, 14'h0123});
		@(posedge clk_sys);
		mem_rd_i   <= 1'b0;
		cpu_addr_i <= 16'h7F00;
		cpu_dout_i <= 8'h05; // gate array pen select, pen 5
		io_wr_i    <= 1'b1;
		@(posedge clk_sys);
		io_wr_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		cpu_addr_i <= 16'h3FCF;
		mem_rd_i   <= 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("mf2_dout_o", mf2_dout_o, 8'h05);
		@(posedge clk_sys);
		mem_rd_i   <= 1'b0;
		cpu_addr_i <= 16'hFEEA;
		io_wr_i    <= 1'b1;
		@(posedge clk_sys);
		io_wr_i <= 1'b0;
		@(posedge clk_sys);
		cpu_addr_i <= 16'h3FCF;
		mem_rd_i   <= 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("mf2_dout_o", mf2_dout_o, 8'hFF);
		check_value("mf2_ram_en_o", mf2_ram_en_o, 1'b0);

		if (err_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_stop();
		end
	end

endmodule

/* rtl/cpc_support_top.sv */
// memory/loader support for the cpc 6128; sdram and tape player sit outside
// cpu_reset_o is held high through hard_reset and every rom or expansion download
`timescale 1ns/1ps

module cpc_support_top (
	input  logic                        clk_sys,
	input  logic                        hard_reset,
	input  logic                        reset_req_i,
	input  logic                        model_i,
	input  logic                        ioctl_download_i,
	input  logic                        ioctl_wr_i,
	input  logic [7:0]                  ioctl_index_i,
	input  logic [24:0]                 ioctl_addr_i,
	input  cpc_bus_pkg::cpu_data_t      ioctl_dout_i,
	input  logic [15:0]                 ioctl_file_ext_i,
	input  logic                        rom_hidden_i,
	input  logic                        mem_rd_i,
	input  logic                        mem_wr_i,
	input  cpc_loader_pkg::sdram_addr_t mem_addr_i,
	input  cpc_bus_pkg::cpu_addr_u      cpu_addr_i,
	input  cpc_bus_pkg::cpu_data_t      cpu_dout_i,
	input  logic                        tape_ack_i,
	input  logic                        tape_data_req_i,
	input  logic [1:0]                  mf2_mode_i,
	input  logic                        key_nmi_i,
	input  logic                        m1_i,
	input  logic                        io_wr_i,
	output logic                        ce_4p_o,
	output logic                        ce_4n_o,
	output logic                        ce_8_o,
	output logic                        ce_16_o,
	output cpc_loader_pkg::dl_kind_t    dl_kind_o,
	output logic                        sdram_oe_o,
	output logic                        sdram_we_o,
	output cpc_loader_pkg::sdram_addr_t sdram_addr_o,
	output logic [1:0]                  sdram_bank_o,
	output cpc_bus_pkg::cpu_data_t      sdram_din_o,
	output logic                        rom_mask_o,
	output cpc_loader_pkg::sdram_addr_t tape_addr_o,
	output logic                        tape_wr_o,
	output logic                        tape_rd_o,
	output logic                        tape_data_ack_o,
	output logic                        tape_restart_o,
	output logic                        nmi_o,
	output logic                        mf2_rom_en_o,
	output logic                        mf2_ram_en_o,
	output cpc_bus_pkg::cpu_data_t      mf2_dout_o,
	output logic                        cpu_reset_o,
	output logic                        model_o
);
	import cpc_loader_pkg::*;

	// cpu reset and model latch
	always_ff @(posedge clk_sys or posedge hard_reset) begin
		if (hard_reset) begin
			cpu_reset_o <= 1'b1;
			model_o     <= 1'b0;
		end else begin
			cpu_reset_o <= reset_req_i | (dl_kind_o == dl_rom) | (dl_kind_o == dl_ext);
			if (cpu_reset_o)
				model_o <= model_i; // model only changes across a reset
		end
	end

	cpc_clock_enables u_ce (
		.clk_sys    (clk_sys),
		.hard_reset (hard_reset),
		.ce_4p_o    (ce_4p_o),
		.ce_4n_o    (ce_4n_o),
		.ce_8_o     (ce_8_o),
		.ce_16_o    (ce_16_o)
	);

	cpc_mem_router u_router (
		.clk_sys          (clk_sys),
		.hard_reset       (hard_reset),
		.cpu_reset_i      (cpu_reset_o),
		.model_i          (model_o),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ioctl_file_ext_i (ioctl_file_ext_i),
		.rom_hidden_i     (rom_hidden_i),
		.mem_rd_i         (mem_rd_i),
		.mem_wr_i         (mem_wr_i),
		.mem_addr_i       (mem_addr_i),
		.cpu_addr_i       (cpu_addr_i),
		.cpu_dout_i       (cpu_dout_i),
		.mf2_rom_en_i     (mf2_rom_en_o),
		.mf2_ram_en_i     (mf2_ram_en_o),
		.dl_kind_o        (dl_kind_o),
		.sdram_oe_o       (sdram_oe_o),
		.sdram_we_o       (sdram_we_o),
		.sdram_addr_o     (sdram_addr_o),
		.sdram_bank_o     (sdram_bank_o),
		.sdram_din_o      (sdram_din_o),
		.rom_mask_o       (rom_mask_o)
	);

	cpc_tape_fetch u_tape (
		.clk_sys          (clk_sys),
		.hard_reset       (hard_reset),
		.cpu_reset_i      (cpu_reset_o),
		.dl_kind_i        (dl_kind_o),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.tape_ack_i       (tape_ack_i),
		.tape_data_req_i  (tape_data_req_i),
		.tape_addr_o      (tape_addr_o),
		.tape_wr_o        (tape_wr_o),
		.tape_rd_o        (tape_rd_o),
		.tape_data_ack_o  (tape_data_ack_o),
		.tape_restart_o   (tape_restart_o)
	);

	cpc_multiface2 u_mf2 (
		.clk_sys      (clk_sys),
		.hard_reset   (hard_reset),
		.cpu_reset_i  (cpu_reset_o),
		.mf2_mode_i   (mf2_mode_i),
		.key_nmi_i    (key_nmi_i),
		.m1_i         (m1_i),
		.io_wr_i      (io_wr_i),
		.mem_rd_i     (mem_rd_i),
		.mem_wr_i     (mem_wr_i),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_dout_i   (cpu_dout_i),
		.nmi_o        (nmi_o),
		.mf2_rom_en_o (mf2_rom_en_o),
		.mf2_ram_en_o (mf2_ram_en_o),
		.mf2_dout_o   (mf2_dout_o)
	);

endmodule

/* rtl/cpc_multiface2.sv */
// multiface two: nmi button, rom/ram paging in the low 16 KB, hw register shadow
// mf2_mode_i is 0 enabled, 1 hidden, 2 disabled; dout is ff when not selected
`timescale 1ns/1ps
`include "cpc_consts.svh"

module cpc_multiface2 (
	input  logic                   clk_sys,
	input  logic                   hard_reset,
	input  logic                   cpu_reset_i,
	input  logic [1:0]             mf2_mode_i,
	input  logic                   key_nmi_i,
	input  logic                   m1_i,
	input  logic                   io_wr_i,
	input  logic                   mem_rd_i,
	input  logic                   mem_wr_i,
	input  cpc_bus_pkg::cpu_addr_u cpu_addr_i,
	input  cpc_bus_pkg::cpu_data_t cpu_dout_i,
	output logic                   nmi_o,
	output logic                   mf2_rom_en_o,
	output logic                   mf2_ram_en_o,
	output cpc_bus_pkg::cpu_data_t mf2_dout_o
);
	import cpc_bus_pkg::*;

	logic        mf2_en;
	logic        mf2_hidden;
	logic        mf2_disabled;
	logic        old_key_nmi;
	logic        old_m1;
	logic        old_io_wr;
	logic        old_mem_wr;
	logic        key_rise;
	logic        m1_rise;
	logic        io_wr_rise;
	logic        mem_wr_rise;
	logic        ctrl_wr;
	logic        shadow_wr;
	logic [12:0] store_addr;
	logic [4:0]  pen_idx;
	logic [3:0]  crtc_reg;
	logic [12:0] ram_a;
	logic [12:0] ram_a_nxt;
	logic        ram_we;
	logic        ram_we_nxt;
	cpu_data_t   ram_in;
	cpu_data_t   ram_out;
	cpu_data_t   mf2_ram [8192];

	assign mf2_disabled = mf2_mode_i[1];
	assign key_rise     = key_nmi_i & ~old_key_nmi;
	assign m1_rise      = m1_i & ~old_m1;
	assign io_wr_rise   = io_wr_i & ~old_io_wr;
	assign mem_wr_rise  = mem_wr_i & ~old_mem_wr;

	// window 0 rom, window 1 ram
	assign mf2_rom_en_o = mf2_en & (cpu_addr_i.mem.window == 3'd0);
	assign mf2_ram_en_o = mf2_en & (cpu_addr_i.mem.window == 3'd1);
	assign mf2_dout_o   = (mf2_ram_en_o & mem_rd_i) ? ram_out : 8'hFF;

	//////////////////////////////////////////////////
	// hardware register shadow slots

	always_comb begin
		casez ({cpu_addr_i.io.port_hi, cpu_dout_i[7:6]})
			{8'h7F, 2'b00}: store_addr = 13'h1FCF; // pen select
			{8'h7F, 2'b01}: store_addr = pen_idx[4] ? 13'h1FDF : {9'h1F9, pen_idx[3:0]};
			{8'h7F, 2'b10}: store_addr = 13'h1FEF; // mode
			{8'h7F, 2'b11}: store_addr = 13'h1FFF; // ram banking
			{8'hBC, 2'b??}: store_addr = 13'h1CFF; // crtc select
			{8'hBD, 2'b??}: store_addr = {9'h1DB, crtc_reg};
			{8'hF7, 2'b??}: store_addr = 13'h17FF; // ppi control
			{8'hDF, 2'b??}: store_addr = 13'h1AAC; // upper rom select
			default:        store_addr = 13'h0000;
		endcase
	end

	assign ctrl_wr   = io_wr_rise & (cpu_addr_i[15:2] == `CPC_MF2_CTRL_PORT);
	assign shadow_wr = io_wr_rise & (|store_addr);

	always_comb begin
		ram_a_nxt  = cpu_addr_i.mem.offset;
		ram_we_nxt = mem_wr_rise & mf2_ram_en_o;
		if (shadow_wr) begin
			ram_a_nxt  = store_addr;
			ram_we_nxt = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// nmi and paging

	always_ff @(posedge clk_sys or posedge hard_reset) begin
		if (hard_reset) begin
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
			old_mem_wr  <= 1'b0;
			ram_we      <= 1'b0;
			mf2_en      <= 1'b0;
			mf2_hidden  <= 1'b0;
			nmi_o       <= 1'b0;
		end else begin
			old_key_nmi <= key_nmi_i;
			old_m1      <= m1_i;
			old_io_wr   <= io_wr_i;
			old_mem_wr  <= mem_wr_i;
			ram_we      <= ram_we_nxt;

			if (cpu_reset_i) begin
				mf2_en     <= 1'b0;
				mf2_hidden <= |mf2_mode_i;
				nmi_o      <= 1'b0;
			end else begin
				if (key_rise && !mf2_en && !mf2_disabled)
					nmi_o <= 1'b1;
				// nmi handler fetch pages the cartridge in
				if (nmi_o && m1_rise && cpu_addr_i == `CPC_MF2_NMI_VEC) begin
					mf2_en     <= 1'b1;
					mf2_hidden <= 1'b0;
					nmi_o      <= 1'b0;
				end
				if (mf2_en && m1_rise && cpu_addr_i == `CPC_MF2_HIDE_VEC)
					mf2_hidden <= 1'b1;
				if (ctrl_wr)
					mf2_en <= ~cpu_addr_i.io.port_lo[1] & ~mf2_hidden; // fee8 in, feea out
			end
		end
	end

	//////////////////////////////////////////////////
	// 8 KB ram, two cycles from address to data

	always_ff @(posedge clk_sys) begin
		ram_a  <= ram_a_nxt;
		ram_in <= cpu_dout_i;
		if (shadow_wr && cpu_addr_i.io.port_hi == 8'h7F && cpu_dout_i[7:6] == 2'b00)
			pen_idx <= cpu_dout_i[4:0];
		if (shadow_wr && cpu_addr_i.io.port_hi == 8'hBC)
			crtc_reg <= cpu_dout_i[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mf2_ram[ram_a] <= ram_in;
			ram_out        <= ram_in;
		end else begin
			ram_out <= mf2_ram[ram_a];
		end
	end

endmodule

/* rtl/cpc_tape_fetch.sv */
// cdt tape store and playback fetch against the toggling sdram ack
// one byte per toggle of tape_data_req_i, answered by copying it to tape_data_ack_o
`timescale 1ns/1ps

module cpc_tape_fetch (
	input  logic                        clk_sys,
	input  logic                        hard_reset,
	input  logic                        cpu_reset_i,
	input  cpc_loader_pkg::dl_kind_t    dl_kind_i,
	input  logic                        ioctl_download_i,
	input  logic                        ioctl_wr_i,
	input  logic [24:0]                 ioctl_addr_i,
	input  logic                        tape_ack_i,
	input  logic                        tape_data_req_i,
	output cpc_loader_pkg::sdram_addr_t tape_addr_o,
	output logic                        tape_wr_o,
	output logic                        tape_rd_o,
	output logic                        tape_data_ack_o,
	output logic                        tape_restart_o
);
	import cpc_loader_pkg::*;

	logic        tape_dl;
	logic        old_wr;
	logic        old_ack;
	logic        ack_edge;
	sdram_addr_t play_addr;
	sdram_addr_t last_addr;

	assign tape_dl  = (dl_kind_i == dl_tape);
	assign ack_edge = tape_ack_i ^ old_ack;

	// download writes go straight to the ioctl address
	assign tape_addr_o = tape_dl ? ioctl_addr_i[`CPC_SDRAM_AW-1:0] : play_addr;

	always_ff @(posedge clk_sys or posedge hard_reset) begin
		if (hard_reset) begin
			old_wr          <= 1'b0;
			old_ack         <= 1'b0;
			tape_wr_o       <= 1'b0;
			tape_rd_o       <= 1'b0;
			tape_data_ack_o <= 1'b0;
			tape_restart_o  <= 1'b0;
			play_addr       <= '0;
			last_addr       <= '0;
		end else begin
			old_wr  <= ioctl_wr_i;
			old_ack <= tape_ack_i;

			// store: one request per ioctl write, held until acked
			if (tape_dl) begin
				if (ack_edge)
					tape_wr_o <= 1'b0;
				if (!old_wr && ioctl_wr_i)
					tape_wr_o <= 1'b1;
			end

			if (cpu_reset_i) begin
				play_addr      <= '0;
				last_addr      <= '0;
				tape_rd_o      <= 1'b0;
				tape_restart_o <= 1'b1;
			end else begin
				tape_restart_o <= 1'b0;
				if (tape_dl) begin
					play_addr      <= '0;
					last_addr      <= tape_addr_o;
					tape_restart_o <= 1'b1; // player starts over on new data
				end
				// playback
				if (!ioctl_download_i && tape_rd_o && ack_edge) begin
					tape_data_ack_o <= tape_data_req_i;
					tape_rd_o       <= 1'b0;
					play_addr       <= play_addr + 1'b1;
				end else if (!ioctl_download_i && !tape_rd_o && play_addr <= last_addr &&
				             (tape_data_req_i ^ tape_data_ack_o)) begin
					tape_rd_o <= 1'b1;
				end
			end
		end
	end

endmodule

/* rtl/cpc_mem_router.sv */
// loader page map and sdram request steering; loader owns sdram while cpu_reset_i is high
// request outputs are combinational, rom_mask_o lags mem_addr_i by one cycle
`timescale 1ns/1ps
`include "cpc_consts.svh"

module cpc_mem_router (
	input  logic                        clk_sys,
	input  logic                        hard_reset,
	input  logic                        cpu_reset_i,
	input  logic                        model_i,
	input  logic                        ioctl_download_i,
	input  logic                        ioctl_wr_i,
	input  logic [7:0]                  ioctl_index_i,
	input  logic [24:0]                 ioctl_addr_i,
	input  cpc_bus_pkg::cpu_data_t      ioctl_dout_i,
	input  logic [15:0]                 ioctl_file_ext_i,
	input  logic                        rom_hidden_i,
	input  logic                        mem_rd_i,
	input  logic                        mem_wr_i,
	input  cpc_loader_pkg::sdram_addr_t mem_addr_i,
	input  cpc_bus_pkg::cpu_addr_u      cpu_addr_i,
	input  cpc_bus_pkg::cpu_data_t      cpu_dout_i,
	input  logic                        mf2_rom_en_i,
	input  logic                        mf2_ram_en_i,
	output cpc_loader_pkg::dl_kind_t    dl_kind_o,
	output logic                        sdram_oe_o,
	output logic                        sdram_we_o,
	output cpc_loader_pkg::sdram_addr_t sdram_addr_o,
	output logic [1:0]                  sdram_bank_o,
	output cpc_bus_pkg::cpu_data_t      sdram_din_o,
	output logic                        rom_mask_o
);
	import cpc_loader_pkg::*;

	// {valid, value} of one ascii hex digit, upper case only
	function automatic logic [4:0] hex_nibble(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, c[3:0]};
		if (c >= "A" && c <= "F")
			return {1'b1, c[3:0] + 4'd9};
		return 5'd0;
	endfunction

	logic         boot_sel;     // rom or expansion download
	logic         boot_wr;
	rom_page_t    boot_page;
	sdram_addr_t  boot_a;
	logic [1:0]   boot_bank;
	rom_page_t    ext_page;
	logic         combo;
	rom_page_t    page_dec;
	logic         combo_dec;
	logic [4:0]   nib_hi;
	logic [4:0]   nib_lo;
	logic         old_download;
	logic         old_wr;
	logic [255:0] rom_map;      // one bit per upper-half page
	logic [7:0]   map_addr;

	//////////////////////////////////////////////////
	// download decode

	always_comb begin
		dl_kind_o = dl_none;
		if (ioctl_download_i) begin
			case (ioctl_index_i)
				`CPC_IDX_ROM:  dl_kind_o = dl_rom;
				`CPC_IDX_DSK:  dl_kind_o = dl_disk;
				`CPC_IDX_EXT:  dl_kind_o = dl_ext;
				`CPC_IDX_TAPE: dl_kind_o = dl_tape;
				default:       dl_kind_o = dl_none;
			endcase
		end
	end

	assign boot_sel = (dl_kind_o == dl_rom) || (dl_kind_o == dl_ext);

	// page from the two-character extension
	always_comb begin
		nib_hi    = hex_nibble(ioctl_file_ext_i[15:8]);
		nib_lo    = hex_nibble(ioctl_file_ext_i[7:0]);
		page_dec  = `CPC_PAGE_BADEXT;
		combo_dec = 1'b0;
		if (nib_hi[4])
			page_dec[7:4] = nib_hi[3:0];
		if (nib_lo[4])
			page_dec[3:0] = nib_lo[3:0];
		if (ioctl_file_ext_i == "ZZ")
			page_dec = `CPC_PAGE_LOWER;
		if (ioctl_file_ext_i == "Z0") begin
			page_dec  = `CPC_PAGE_LOWER; // lower rom, then on into the upper pages
			combo_dec = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// loader address map

	always_comb begin
		boot_wr   = boot_sel & ioctl_wr_i;
		boot_page = `CPC_PAGE_MF2;
		boot_bank = 2'd0;
		if (dl_kind_o == dl_ext) begin
			boot_page = {ext_page[8], ext_page[7:0] + ioctl_addr_i[21:14]};
			boot_bank = {1'b0, model_i};
		end else begin
			case (ioctl_addr_i[24:14])
				11'd0, 11'd4: boot_page = `CPC_PAGE_LOWER;
				11'd1, 11'd5: boot_page = `CPC_PAGE_BASIC;
				11'd2, 11'd6: boot_page = `CPC_PAGE_AMSDOS;
				11'd3, 11'd7: boot_page = `CPC_PAGE_MF2;
				default:      boot_wr   = 1'b0; // beyond the rom image
			endcase
			if (ioctl_addr_i[24:17] == 8'd0)
				boot_bank = {1'b0, ioctl_addr_i[16]}; // blocks 4-7 go to bank 1
		end
	end

	assign boot_a = {boot_page, ioctl_addr_i[`CPC_OFFSET_W-1:0]};

	always_ff @(posedge clk_sys or posedge hard_reset) begin
		if (hard_reset) begin
			old_download <= 1'b0;
			old_wr       <= 1'b0;
			ext_page     <= `CPC_PAGE_LOWER;
			combo        <= 1'b0;
			rom_map      <= '0;
		end else begin
			old_download <= ioctl_download_i;
			old_wr       <= ioctl_wr_i;

			// byte written, page counts as loaded
			if (boot_sel && old_wr && !ioctl_wr_i) begin
				if (boot_a[22])
					rom_map[boot_a[21:14]] <= 1'b1;
				if (combo && &boot_a[13:0]) begin
					combo    <= 1'b0;
					ext_page <= `CPC_PAGE_MF2; // next block wraps to page 100
				end
			end

			if (!old_download && ioctl_download_i && dl_kind_o == dl_ext) begin
				ext_page <= page_dec;
				combo    <= combo_dec;
			end
		end
	end

	//////////////////////////////////////////////////
	// rom mask and sdram request

	always_ff @(posedge clk_sys)
		map_addr <= mem_addr_i[`CPC_SDRAM_AW-2:`CPC_OFFSET_W];

	// unloaded upper page, or page ff while the rom is hidden
	assign rom_mask_o = mem_addr_i[22] & (~rom_map[map_addr] | (&map_addr & rom_hidden_i));

	assign sdram_oe_o = cpu_reset_i ? 1'b0 : mem_rd_i & ~mf2_ram_en_i & ~rom_mask_o;
	assign sdram_we_o = cpu_reset_i ? boot_wr : mem_wr_i & ~mf2_ram_en_i & ~mf2_rom_en_i;

	// mf2 rom lives in window 0, so offset bit 13 is zero
	assign sdram_addr_o = cpu_reset_i  ? boot_a :
	                      mf2_rom_en_i ? {`CPC_PAGE_MF2, 1'b0, cpu_addr_i.mem.offset} :
	                      mem_addr_i;

	assign sdram_bank_o = cpu_reset_i ? boot_bank : {1'b0, model_i};
	assign sdram_din_o  = cpu_reset_i ? ioctl_dout_i : cpu_dout_i;

endmodule

/* rtl/cpc_clock_enables.sv */
// clock enables from a free running divide-by-16 counter on clk_sys
// enables are registered and stay low while hard_reset is high
`timescale 1ns/1ps

module cpc_clock_enables (
	input  logic clk_sys,
	input  logic hard_reset,
	output logic ce_4p_o,
	output logic ce_4n_o,
	output logic ce_8_o,
	output logic ce_16_o
);

	logic [3:0] div;

	always_ff @(posedge clk_sys or posedge hard_reset) begin
		if (hard_reset) begin
			div     <= 4'd0;
			ce_4p_o <= 1'b0;
			ce_4n_o <= 1'b0;
			ce_8_o  <= 1'b0;
			ce_16_o <= 1'b0;
		end else begin
			div     <= div + 4'd1;
			ce_4p_o <= (div == 4'd0);     // cpu phase p
			ce_4n_o <= (div == 4'd8);     // half a cpu cycle later
			ce_8_o  <= (div[2:0] == 3'd0); // fdc
			ce_16_o <= (div[1:0] == 2'd0); // pixel / loader
		end
	end

endmodule

/* rtl/cpc_bus_pkg.sv */
// z80 bus types; the address word is read as an i/o port or as a memory address
// the memory view splits the 64 KB space into eight 8 KB windows

package cpc_bus_pkg;

	typedef logic [7:0] cpu_data_t;

	// port view, high byte carries the device select
	typedef struct packed {
		logic [7:0] port_hi;
		logic [7:0] port_lo;
	} cpu_io_addr_t;

	// memory view, 8 KB windows
	typedef struct packed {
		logic [2:0]  window;
		logic [12:0] offset;
	} cpu_mem_addr_t;

	typedef union packed {
		cpu_io_addr_t  io;
		cpu_mem_addr_t mem;
	} cpu_addr_u;

endpackage

/* rtl/cpc_loader_pkg.sv */
// loader side types: sdram addresses, ROM pages, download kinds
// widths come from cpc_consts.svh
`include "cpc_consts.svh"

package cpc_loader_pkg;

	// byte address into the sdram
	typedef logic [`CPC_SDRAM_AW-1:0] sdram_addr_t;

	// 16 KB page number, top bit is the ROM half
	typedef logic [`CPC_PAGE_W-1:0] rom_page_t;

	// what the ioctl download currently carries
	typedef enum logic [2:0] {
		dl_none,
		dl_rom,
		dl_disk,
		dl_ext,
		dl_tape
	} dl_kind_t;

endpackage

/* rtl/cpc_consts.svh */
// width, download index, page and multiface constants for the CPC memory blocks
// pages are 9 bits wide, bit 8 picks the upper ROM half of the SDRAM
`ifndef CPC_CONSTS_SVH
`define CPC_CONSTS_SVH

//////////////////////////////////////////////////
// widths

// sdram byte address, page number, offset inside a 16 KB page
`define CPC_SDRAM_AW 23
`define CPC_PAGE_W 9
`define CPC_OFFSET_W 14

//////////////////////////////////////////////////
// ioctl download indices

`define CPC_IDX_ROM 8'd0
`define CPC_IDX_DSK 8'd1
`define CPC_IDX_EXT 8'd3
`define CPC_IDX_TAPE 8'd4

//////////////////////////////////////////////////
// sdram pages

`define CPC_PAGE_LOWER 9'h000
`define CPC_PAGE_BASIC 9'h100
`define CPC_PAGE_AMSDOS 9'h107
`define CPC_PAGE_MF2 9'h1FF
// spare page, catches expansion files with a malformed extension
`define CPC_PAGE_BADEXT 9'h1EE

//////////////////////////////////////////////////
// multiface two

`define CPC_MF2_NMI_VEC 16'h0066
`define CPC_MF2_HIDE_VEC 16'h0065
// fee8/feea with the two low bits dropped, bit 1 selects page out
`define CPC_MF2_CTRL_PORT 14'b11_1111_1011_1010

`endif
